// File: src/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ================================================
// Cache geometry
// ================================================
`define DC_XLEN         32      // Address and data word width
`define DC_WORDS        4       // Words per line
`define DC_WAYS         4       // Associativity
`define DC_SETS         4       // Sets per way

// ================================================
// Address split
// ================================================
// Tag | index | word offset | byte offset
`define DC_BYTE_BITS    2
`define DC_WORD_BITS    2
`define DC_INDEX_BITS   2
`define DC_TAG_BITS     (`DC_XLEN - `DC_BYTE_BITS - `DC_WORD_BITS - `DC_INDEX_BITS)

`endif

// File: src/dcache_pkg.sv
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    // Processor side
    typedef logic [`DC_XLEN-1:0]           addr_t;     // Byte address
    typedef logic [`DC_XLEN-1:0]           word_t;     // Data word
    typedef logic [`DC_XLEN/8-1:0]         be_t;       // One bit per byte lane

    // Word 0 sits in the low bits
    typedef logic [`DC_WORDS*`DC_XLEN-1:0] line_t;

    // Address fields
    typedef logic [`DC_TAG_BITS-1:0]       tag_t;
    typedef logic [`DC_INDEX_BITS-1:0]     index_t;
    typedef logic [`DC_WORD_BITS-1:0]      offset_t;

    // Way select and FIFO pointer
    typedef logic [$clog2(`DC_WAYS)-1:0]   way_t;

endpackage

`default_nettype wire

// File: src/dcache_array_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dcache_array_if;
    import dcache_pkg::*;

    // Controller to storage
    index_t  index;         // Set address, RAM read is registered
    tag_t    look;          // Tag under compare
    logic    wr_en;
    way_t    wr_way;
    tag_t    wr_tag;
    line_t   wr_line;
    logic    wr_dirty;      // Dirty flag stored with the line
    logic    fill;          // Refill write, bumps the FIFO pointer

    // Storage to controller, one cycle after index
    logic    hit;
    way_t    hit_way;
    line_t   hit_line;
    way_t    victim_way;
    tag_t    victim_tag;
    line_t   victim_line;
    logic    victim_dirty;

    modport ctrl (
        output index, look, wr_en, wr_way, wr_tag, wr_line, wr_dirty, fill,
        input  hit, hit_way, hit_line, victim_way, victim_tag, victim_line, victim_dirty
    );

    modport ways (
        input  index, look, wr_en, wr_way, wr_tag, wr_line, wr_dirty, fill,
        output hit, hit_way, hit_line, victim_way, victim_tag, victim_line, victim_dirty
    );

endinterface

`default_nettype wire

// File: src/dcache_sram.sv
`timescale 1ns/1ns
`default_nettype none

// Single port block RAM model
// Read data shows up the cycle after the address
module dcache_sram #(
    parameter type entry_t = logic [31:0],      // Tag or line
    parameter int  DEPTH   = 4                  // One entry per set
) (
    input  wire logic                     clk_i,
    input  wire logic                     we_i,
    input  wire logic [$clog2(DEPTH)-1:0] addr_i,
    input  wire entry_t                   data_i,
    output entry_t                        data_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            mem[addr_i] <= data_i;
        end
        data_o <= mem[addr_i];      // Old data on a same-address write
    end

endmodule

`default_nettype wire

// File: src/dcache_word_merge.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

// Word pick and byte lane insert on one line
module dcache_word_merge (
    input  wire dcache_pkg::line_t   line_i,
    input  wire dcache_pkg::offset_t offset_i,
    input  wire dcache_pkg::be_t     be_i,
    input  wire dcache_pkg::word_t   data_i,
    output dcache_pkg::word_t        word_o,
    output dcache_pkg::line_t        line_o
);
    import dcache_pkg::*;

    word_t merged;

    always_comb
    begin
        word_o = line_i[offset_i*`DC_XLEN +: `DC_XLEN];     // Selected word

        // Enabled lanes from store data, rest kept
        merged = word_o;
        for (int b = 0; b < `DC_XLEN/8; b++)
        begin
            if (be_i[b])
            begin
                merged[b*8 +: 8] = data_i[b*8 +: 8];
            end
        end

        line_o = line_i;
        line_o[offset_i*`DC_XLEN +: `DC_XLEN] = merged;
    end

endmodule

`default_nettype wire

// File: src/dcache_ways.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_ways (
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    dcache_array_if.ways  arr_i
);
    import dcache_pkg::*;

    index_t              index_q;                   // Set behind the RAM outputs
    logic [`DC_WAYS-1:0] valid_q  [`DC_SETS];
    logic [`DC_WAYS-1:0] dirty_q  [`DC_SETS];
    way_t                fifo_ptr [`DC_SETS];       // Next victim per set
    tag_t                tag_rd   [`DC_WAYS];
    line_t               line_rd  [`DC_WAYS];
    logic [`DC_WAYS-1:0] way_hit;

    // ================================================
    // Tag and data RAMs
    // ================================================
    for (genvar w = 0; w < `DC_WAYS; w++)
    begin : g_way
        dcache_sram #(.entry_t(tag_t), .DEPTH(`DC_SETS)) u_tag (
            .clk_i  (clk_i),
            .we_i   (arr_i.wr_en && (arr_i.wr_way == way_t'(w))),
            .addr_i (arr_i.index),
            .data_i (arr_i.wr_tag),
            .data_o (tag_rd[w])
        );

        dcache_sram #(.entry_t(line_t), .DEPTH(`DC_SETS)) u_data (
            .clk_i  (clk_i),
            .we_i   (arr_i.wr_en && (arr_i.wr_way == way_t'(w))),
            .addr_i (arr_i.index),
            .data_i (arr_i.wr_line),
            .data_o (line_rd[w])
        );

        assign way_hit[w] = valid_q[index_q][w] && (tag_rd[w] == arr_i.look);
    end

    // Track the set so flags line up with RAM data
    always_ff @(posedge clk_i)
    begin
        index_q <= arr_i.index;
    end

    // ================================================
    // Valid, dirty and FIFO pointers
    // ================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `DC_SETS; s++)
            begin
                valid_q[s]  <= '0;
                dirty_q[s]  <= '0;
                fifo_ptr[s] <= '0;
            end
        end
        else
        begin
            if (arr_i.wr_en)
            begin
                valid_q[arr_i.index][arr_i.wr_way] <= 1'b1;
                dirty_q[arr_i.index][arr_i.wr_way] <= arr_i.wr_dirty;
            end
            if (arr_i.fill)
            begin
                fifo_ptr[arr_i.index] <= fifo_ptr[arr_i.index] + 1'b1;  // Round robin
            end
        end
    end

    // Hit encode, at most one way matches
    always_comb
    begin
        arr_i.hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            if (way_hit[w])
            begin
                arr_i.hit_way = way_t'(w);
            end
        end
    end

    assign arr_i.hit          = |way_hit;
    assign arr_i.hit_line     = line_rd[arr_i.hit_way];
    assign arr_i.victim_way   = fifo_ptr[index_q];
    assign arr_i.victim_tag   = tag_rd[arr_i.victim_way];
    assign arr_i.victim_line  = line_rd[arr_i.victim_way];
    assign arr_i.victim_dirty = dirty_q[index_q][arr_i.victim_way];   // Needs write-back

endmodule

`default_nettype wire

// File: src/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    // Processor side
    input  wire logic              p_strobe_i,
    input  wire logic              p_rw_i,         // 1 is write
    input  wire dcache_pkg::addr_t p_addr_i,
    input  wire dcache_pkg::be_t   p_be_i,
    input  wire dcache_pkg::word_t p_data_i,
    output dcache_pkg::word_t      p_data_o,
    output logic                   p_ready_o,
    // Memory side
    output logic                   m_strobe_o,
    output logic                   m_rw_o,
    output dcache_pkg::addr_t      m_addr_o,
    output dcache_pkg::line_t      m_data_o,
    input  wire logic              m_ready_i,
    input  wire dcache_pkg::line_t m_data_i,
    // Storage
    dcache_array_if.ctrl           arr_o
);
    import dcache_pkg::*;

    localparam int LINE_LSB = `DC_BYTE_BITS + `DC_WORD_BITS;

    typedef enum logic [2:0] {
        S_IDLE, S_LOOKUP, S_WRITEBACK, S_REFILL, S_FILL, S_RESPOND
    } state_t;

    state_t  state_q, state_d;
    addr_t   addr_q;            // Captured request
    logic    rw_q;
    be_t     be_q;
    word_t   data_q;
    line_t   refill_q;          // Line read from memory
    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    line_t   merge_line;
    line_t   merged_line;

    assign req_tag    = addr_q[`DC_XLEN-1 -: `DC_TAG_BITS];
    assign req_index  = addr_q[LINE_LSB +: `DC_INDEX_BITS];
    assign req_offset = addr_q[`DC_BYTE_BITS +: `DC_WORD_BITS];

    // ================================================
    // Request capture
    // ================================================
    always_ff @(posedge clk_i)
    begin
        if (state_q == S_IDLE && p_strobe_i)
        begin
            addr_q <= p_addr_i;
            rw_q   <= p_rw_i;
            be_q   <= p_be_i;
            data_q <= p_data_i;
        end
        if (state_q == S_REFILL && m_ready_i)
        begin
            refill_q <= m_data_i;
        end
    end

    // RAM read starts in the strobe cycle
    assign arr_o.index = (state_q == S_IDLE && p_strobe_i) ?
                         p_addr_i[LINE_LSB +: `DC_INDEX_BITS] : req_index;

    // ================================================
    // FSM
    // ================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= S_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:      if (p_strobe_i) state_d = S_LOOKUP;
            S_LOOKUP:
            begin
                if (arr_o.hit)
                    state_d = S_IDLE;
                else if (arr_o.victim_dirty)
                    state_d = S_WRITEBACK;      // Victim first
                else
                    state_d = S_REFILL;
            end
            S_WRITEBACK: if (m_ready_i) state_d = S_REFILL;
            S_REFILL:    if (m_ready_i) state_d = S_FILL;
            S_FILL:      state_d = S_RESPOND;
            default:     state_d = S_IDLE;      // Respond
        endcase
    end

    // Hit line in lookup, refilled line later
    assign merge_line = (state_q == S_LOOKUP) ? arr_o.hit_line : refill_q;

    dcache_word_merge u_merge (
        .line_i   (merge_line),
        .offset_i (req_offset),
        .be_i     (be_q),
        .data_i   (data_q),
        .word_o   (p_data_o),
        .line_o   (merged_line)
    );

    assign p_ready_o = (state_q == S_LOOKUP && arr_o.hit) || (state_q == S_RESPOND);

    // Storage writes
    always_comb
    begin
        arr_o.look     = req_tag;
        arr_o.wr_en    = 1'b0;
        arr_o.wr_way   = arr_o.hit_way;
        arr_o.wr_tag   = req_tag;
        arr_o.wr_line  = merged_line;
        arr_o.wr_dirty = 1'b1;          // Store hit
        arr_o.fill     = 1'b0;
        if (state_q == S_LOOKUP)
        begin
            arr_o.wr_en = arr_o.hit && rw_q;
        end
        else if (state_q == S_FILL)
        begin
            arr_o.wr_en    = 1'b1;
            arr_o.wr_way   = arr_o.victim_way;
            arr_o.wr_line  = rw_q ? merged_line : refill_q;
            arr_o.wr_dirty = rw_q;      // Write allocate
            arr_o.fill     = 1'b1;
        end
    end

    // ================================================
    // Memory port
    // ================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
        end
        else
        begin
            // One pulse on entry to either memory state
            m_strobe_o <= (state_d != state_q) &&
                          (state_d == S_WRITEBACK || state_d == S_REFILL);
            if (state_d != state_q && state_d == S_WRITEBACK)
                m_rw_o <= 1'b1;
            else if (state_d != state_q && state_d == S_REFILL)
                m_rw_o <= 1'b0;
        end
    end

    // Address and data held until ready
    always_ff @(posedge clk_i)
    begin
        if (state_q == S_LOOKUP && state_d == S_WRITEBACK)
        begin
            m_addr_o <= {arr_o.victim_tag, req_index, {LINE_LSB{1'b0}}};
            m_data_o <= arr_o.victim_line;
        end
        else if (state_d == S_REFILL && state_q != S_REFILL)
        begin
            m_addr_o <= {addr_q[`DC_XLEN-1:LINE_LSB], {LINE_LSB{1'b0}}};  // Line aligned
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

// L1 data cache, 4-way write-back
module dcache_top (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    // Processor
    input  wire logic              p_strobe_i,
    input  wire logic              p_rw_i,
    input  wire dcache_pkg::addr_t p_addr_i,
    input  wire dcache_pkg::be_t   p_be_i,
    input  wire dcache_pkg::word_t p_data_i,
    output dcache_pkg::word_t      p_data_o,
    output logic                   p_ready_o,
    // Memory
    output logic                   m_strobe_o,
    output logic                   m_rw_o,
    output dcache_pkg::addr_t      m_addr_o,
    output dcache_pkg::line_t      m_data_o,
    input  wire logic              m_ready_i,
    input  wire dcache_pkg::line_t m_data_i
);

    dcache_array_if arr ();     // Controller to tag and data arrays

    dcache_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe_i),
        .p_rw_i     (p_rw_i),
        .p_addr_i   (p_addr_i),
        .p_be_i     (p_be_i),
        .p_data_i   (p_data_i),
        .p_data_o   (p_data_o),
        .p_ready_o  (p_ready_o),
        .m_strobe_o (m_strobe_o),
        .m_rw_o     (m_rw_o),
        .m_addr_o   (m_addr_o),
        .m_data_o   (m_data_o),
        .m_ready_i  (m_ready_i),
        .m_data_i   (m_data_i),
        .arr_o      (arr)
    );

    dcache_ways u_ways (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .arr_i (arr)
    );

endmodule

`default_nettype wire

// File: verif/dcache_asserts.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

// Handshake rules on the controller ports
module dcache_asserts (
    input wire logic              clk_i,
    input wire logic              rst_i,
    input wire logic              m_strobe_i,
    input wire logic              p_ready_i,
    input wire dcache_pkg::addr_t m_addr_i
);

    localparam int LINE_LSB = `DC_BYTE_BITS + `DC_WORD_BITS;

    int fail_count = 0;     // Summed into the testbench error total

    // ================================================
    // Single cycle pulses
    // ================================================
    a_m_strobe_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_i |=> !m_strobe_i)
    else
    begin
        fail_count++;
        $error("m_strobe_o high for two cycles in a row");
    end

    a_p_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_i |=> !p_ready_i)
    else
    begin
        fail_count++;
        $error("p_ready_o high for two cycles in a row");
    end

    // Response and memory access never overlap
    a_ready_vs_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
        !(p_ready_i && m_strobe_i))
    else
    begin
        fail_count++;
        $error("p_ready_o and m_strobe_o high together");
    end

    // Memory only sees whole lines
    a_line_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_i |-> (m_addr_i[LINE_LSB-1:0] == '0))
    else
    begin
        fail_count++;
        $error("m_addr_o not line aligned");
    end

endmodule

bind dcache_ctrl dcache_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .m_strobe_i (m_strobe_o),
    .p_ready_i  (p_ready_o),
    .m_addr_i   (m_addr_o)
);

`default_nettype wire

// File: verif/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_REQ   = 400;
    localparam int MAX_CYC   = 12000;       // 400 requests at 28 cycles, plus margin
    localparam int MEM_BYTES = 1024;        // 64 lines of 16 bytes

    logic        clk_i      = 1'b0;
    logic        rst_i      = 1'b1;
    logic        p_strobe_i = 1'b0;
    logic        p_rw_i     = 1'b0;
    addr_t       p_addr_i   = '0;
    be_t         p_be_i     = '0;
    word_t       p_data_i   = '0;
    word_t       p_data_o;
    logic        p_ready_o;
    logic        m_strobe_o;
    logic        m_rw_o;
    addr_t       m_addr_o;
    line_t       m_data_o;
    logic        m_ready_i  = 1'b0;
    line_t       m_data_i   = '0;

    line_t       mem    [64];               // Memory model contents
    logic [7:0]  shadow [MEM_BYTES];        // Expected memory image
    logic [31:0] stim_rng  = 32'd33045;
    logic [31:0] mem_rng   = 32'd33045;
    int          errors    = 0;
    int          cycle_cnt = 0;
    int          mem_reqs  = 0;
    logic        busy      = 1'b0;          // Request outstanding
    logic        exp_rw    = 1'b0;
    word_t       exp_word  = '0;

    dcache_top UUT (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Initial memory word, all address bits mixed in
    function automatic word_t mem_pattern(input addr_t a);
        return {a[15:0] ^ 16'hC3A5, ~a[15:0]} ^ {a[31:16], a[31:16]};
    endfunction

    // Reference model of a processor read
    function automatic word_t ref_word(input addr_t a);
        int base;
        base = int'(a[9:0]);
        return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
    endfunction

    function automatic line_t ref_line(input addr_t a);
        line_t l;
        for (int w = 0; w < 4; w++)
            l[w*32 +: 32] = ref_word(a + addr_t'(w*4));
        return l;
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // ================================================
    // Clock and timeout
    // ================================================
    always #2 clk_i = ~clk_i;               // 4 ns period

    always @(posedge clk_i)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == MAX_CYC)
        begin
            $display("Timeout after %0d cycles, %0d errors so far", cycle_cnt, errors);
            $display("test failed");
            $finish;
        end
    end

    // ================================================
    // Memory model
    // ================================================
    initial
    begin : memory_model
        addr_t req_addr;
        logic  req_rw;
        int    delay;
        forever
        begin
            @(negedge clk_i);
            if (m_strobe_o === 1'b1)
            begin
                req_addr = m_addr_o;
                req_rw   = m_rw_o;
                mem_reqs = mem_reqs + 1;
                mem_rng  = lcg_next(mem_rng);
                delay    = 1 + int'(mem_rng[26:24]);     // 1 to 8 cycles
                assert (req_addr[3:0] == 4'h0 && req_addr < MEM_BYTES)
                else log_error($sformatf("Memory request to bad address %h", req_addr));
                if (req_rw)
                begin
                    // Write-back must carry the newest line
                    assert (m_data_o == ref_line(req_addr))
                    else log_error($sformatf("ERROR m_data_o got %h expected %h",
                                             m_data_o, ref_line(req_addr)));
                    mem[req_addr[9:4]] = m_data_o;
                end
                repeat (delay) @(posedge clk_i);
                #1;
                m_ready_i = 1'b1;
                m_data_i  = req_rw ? '0 : mem[req_addr[9:4]];
                @(posedge clk_i);
                #1;
                m_ready_i = 1'b0;
            end
        end
    end

    // ================================================
    // Response compare
    // ================================================
    always @(negedge clk_i)
    begin
        if (!rst_i)
        begin
            if (p_ready_o === 1'b1)
            begin
                assert (busy) else log_error("p_ready_o pulsed with no request outstanding");
                if (busy && !exp_rw)
                    assert (p_data_o == exp_word)
                    else log_error($sformatf("ERROR p_data_o got %h expected %h",
                                             p_data_o, exp_word));
            end
            assert (m_strobe_o !== 1'b1 || busy)
            else log_error("m_strobe_o pulsed with no request outstanding");
        end
    end

    // ================================================
    // Stimulus
    // ================================================
    initial
    begin : stimulus
        addr_t last_addr;
        int    lat;
        int    reqs_before;
        logic  repeat_rd;
        last_addr = '0;
        for (int a = 0; a < MEM_BYTES; a += 4)
        begin
            mem[a/16][(a%16)*8 +: 32] = mem_pattern(addr_t'(a));
            {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]} = mem_pattern(addr_t'(a));
        end
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        repeat (3) @(posedge clk_i);        // Idle, outputs must stay low
        for (int i = 0; i < NUM_REQ; i++)
        begin
            stim_rng  = lcg_next(stim_rng);
            repeat_rd = (i > 0) && (stim_rng[31:30] == 2'b00);  // Same address again
            @(posedge clk_i);
            #1;
            p_strobe_i  = 1'b1;
            p_rw_i      = repeat_rd ? 1'b0 : stim_rng[29];
            p_addr_i    = repeat_rd ? last_addr : addr_t'({stim_rng[27:20], 2'b00});
            p_be_i      = stim_rng[19:16];
            stim_rng    = lcg_next(stim_rng);
            p_data_i    = stim_rng;
            exp_rw      = p_rw_i;
            exp_word    = ref_word(p_addr_i);
            busy        = 1'b1;
            last_addr   = p_addr_i;
            reqs_before = mem_reqs;
            @(posedge clk_i);
            #1;
            p_strobe_i = 1'b0;
            lat = 0;
            do
            begin
                @(negedge clk_i);
                lat++;
            end
            while (p_ready_o !== 1'b1);
            if (repeat_rd)
                assert (lat == 1 && mem_reqs == reqs_before)
                else log_error($sformatf("Repeated read of %h was no hit, %0d cycles, %0d mem",
                                         last_addr, lat, mem_reqs - reqs_before));
            @(posedge clk_i);
            #1;
            busy = 1'b0;
            if (exp_rw)
                for (int b = 0; b < 4; b++)
                    if (p_be_i[b])
                        shadow[int'(p_addr_i[9:0]) + b] = p_data_i[b*8 +: 8];
        end
        repeat (4) @(posedge clk_i);
        $display("Done: %0d errors, %0d assertion failures", errors,
                 UUT.u_ctrl.u_asserts.fail_count);
        if (errors == 0 && UUT.u_ctrl.u_asserts.fail_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache_top.f
+incdir+src
src/dcache_pkg.sv
src/dcache_array_if.sv
src/dcache_sram.sv
src/dcache_word_merge.sv
src/dcache_ways.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/dcache_asserts.sv
verif/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module dcache_tb -f dcache_top.f -o dcache_sim \
    && ./obj_dir/dcache_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Simulation did not complete"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
